// File: design/pcw_mem_pkg.sv
// ------------------------------
// PCW memory paging package
// Address, bank and request types,
// I/O port numbers and the reset
// values of the paging registers
// ------------------------------

package pcw_mem_pkg;

    typedef logic [15:0] cpu_addr_t;     // Z80 address
    typedef logic [20:0] phys_addr_t;    // 2 MB RAM address
    typedef logic [7:0]  bank_reg_t;     // Bit 7 = PCW mode
    typedef logic [1:0]  seg_t;          // 16K segment from addr 15:14
    typedef logic [7:0]  io_port_t;      // Low byte of I/O address

    // Installed RAM size limits the PCW bank bits
    typedef enum logic [1:0] {
        mem_256k = 2'd0,
        mem_512k = 2'd1,
        mem_1m   = 2'd2,
        mem_2m   = 2'd3
    } mem_size_e;

    typedef struct packed {
        io_port_t    port;
        logic [7:0]  data;
    } io_wr_t;

    typedef struct packed {
        cpu_addr_t   addr;
        logic        write;   // High for memory write
    } mem_req_t;

    typedef struct packed {
        phys_addr_t  addr;
        logic        write;
    } map_result_t;

    localparam io_port_t PORT_BANK0 = 8'hf0;   // 0000-3fff
    localparam io_port_t PORT_BANK1 = 8'hf1;   // 4000-7fff
    localparam io_port_t PORT_BANK2 = 8'hf2;   // 8000-bfff
    localparam io_port_t PORT_BANK3 = 8'hf3;   // c000-ffff
    localparam io_port_t PORT_LOCK  = 8'hf4;   // CPC read lock

    localparam bank_reg_t BANK0_RESET = 8'h80;
    localparam bank_reg_t BANK1_RESET = 8'h81;
    localparam bank_reg_t BANK2_RESET = 8'h82;
    localparam bank_reg_t BANK3_RESET = 8'h83;
    localparam bank_reg_t LOCK_RESET  = 8'hf1;

    localparam int PAGE_BITS     = 14;   // Offset within a 16K page
    localparam int LOCK_BIT_BASE = 4;    // F4 bit for segment 0

endpackage

// File: design/bank_registers.sv
// ------------------------------
// Bank registers
// Decodes CPU I/O writes and holds
// the F0-F3 page registers and the
// F4 CPC read lock register
// ------------------------------

`timescale 1ns/1ps

module bank_registers
    import pcw_mem_pkg::*;
(
    input  logic                  clk_sys,
    input  logic                  reset,
    input  logic                  io_wr_valid,   // One-cycle write strobe
    input  io_wr_t                io_wr,
    output bank_reg_t [3:0]       banks,         // Index = segment
    output bank_reg_t             lock
);

    // Port match per register
    logic hit_bank0;
    logic hit_bank1;
    logic hit_bank2;
    logic hit_bank3;
    logic hit_lock;

    assign hit_bank0 = io_wr_valid && (io_wr.port == PORT_BANK0);
    assign hit_bank1 = io_wr_valid && (io_wr.port == PORT_BANK1);
    assign hit_bank2 = io_wr_valid && (io_wr.port == PORT_BANK2);
    assign hit_bank3 = io_wr_valid && (io_wr.port == PORT_BANK3);
    assign hit_lock  = io_wr_valid && (io_wr.port == PORT_LOCK);

    // Any other port falls through untouched
    always_ff @(posedge clk_sys) begin
        if (reset) begin
            banks[0] <= BANK0_RESET;    // All segments start in PCW mode
            banks[1] <= BANK1_RESET;
            banks[2] <= BANK2_RESET;
            banks[3] <= BANK3_RESET;
            lock     <= LOCK_RESET;
        end else begin
            if (hit_bank0) begin
                banks[0] <= io_wr.data;
            end
            if (hit_bank1) begin
                banks[1] <= io_wr.data;
            end
            if (hit_bank2) begin
                banks[2] <= io_wr.data;
            end
            if (hit_bank3) begin
                banks[3] <= io_wr.data;
            end

            // Lock bits 7:4 follow segments 3..0
            if (hit_lock) begin
                lock <= io_wr.data;
            end
        end
    end

endmodule

// File: design/pcw_bank_map.sv
// ------------------------------
// PCW bank map
// Translates a CPU address with the
// 7-bit PCW bank, masked to the
// installed memory size
// ------------------------------

`timescale 1ns/1ps

module pcw_bank_map
    import pcw_mem_pkg::*;
(
    input  mem_req_t              req,
    input  bank_reg_t [3:0]       banks,
    input  mem_size_e             mem_size,
    output map_result_t           pcw_result
);

    seg_t        seg;
    bank_reg_t   bank_sel;
    logic [6:0]  bank_masked;   // 16K page number in RAM

    assign seg      = req.addr[15:14];
    assign bank_sel = banks[seg];

    // Upper bank bits do not exist on smaller machines
    always_comb begin
        case (mem_size)
            mem_256k: begin
                bank_masked = {3'b000, bank_sel[3:0]};   // 16 pages
            end
            mem_512k: begin
                bank_masked = {2'b00, bank_sel[4:0]};    // 32 pages
            end
            mem_1m: begin
                bank_masked = {1'b0, bank_sel[5:0]};     // 64 pages
            end
            mem_2m: begin
                bank_masked = bank_sel[6:0];             // Full 128 pages
            end
            default: begin
                bank_masked = bank_sel[6:0];
            end
        endcase
    end

    // Page number above the 14-bit offset
    always_comb begin
        pcw_result.addr  = {bank_masked, req.addr[PAGE_BITS-1:0]};
        pcw_result.write = req.write;
    end

endmodule

// File: design/cpc_bank_map.sv
// ------------------------------
// CPC bank map
// Translates a CPU address with a
// 3-bit CPC bank, split read/write
// fields picked through F4 lock bits
// ------------------------------

`timescale 1ns/1ps

module cpc_bank_map
    import pcw_mem_pkg::*;
(
    input  mem_req_t              req,
    input  bank_reg_t [3:0]       banks,
    input  bank_reg_t             lock,
    output map_result_t           cpc_result
);

    seg_t        seg;
    bank_reg_t   bank_sel;
    logic        read_locked;   // Reads follow the write bank
    logic [2:0]  write_bank;
    logic [2:0]  read_bank;
    logic [2:0]  cpc_bank;

    assign seg      = req.addr[15:14];
    assign bank_sel = banks[seg];

    // F4 bit 4 locks segment 0, bit 7 segment 3
    assign read_locked = lock[LOCK_BIT_BASE + seg];

    assign write_bank = bank_sel[2:0];
    assign read_bank  = bank_sel[6:4];

    always_comb begin
        if (req.write) begin
            cpc_bank = write_bank;          // Writes always low field
        end else if (read_locked) begin
            cpc_bank = write_bank;          // Locked read uses the write page
        end else begin
            cpc_bank = read_bank;           // Separate read page
        end
    end

    // Only the bottom 128K is reachable in CPC mode
    always_comb begin
        cpc_result.addr  = {4'b0000, cpc_bank, req.addr[PAGE_BITS-1:0]};
        cpc_result.write = req.write;
    end

endmodule

// File: design/phys_addr_stage.sv
// ------------------------------
// Physical address stage
// Picks PCW or CPC result per segment
// and queues it in a two-entry FIFO
// with valid/ready on both sides
// ------------------------------

`timescale 1ns/1ps

module phys_addr_stage
    import pcw_mem_pkg::*;
(
    input  logic                  clk_sys,
    input  logic                  reset,
    input  logic                  req_valid,
    output logic                  req_ready,
    input  mem_req_t              req,
    input  bank_reg_t [3:0]       banks,
    input  map_result_t           pcw_result,
    input  map_result_t           cpc_result,
    output logic                  out_valid,
    input  logic                  out_ready,
    output map_result_t           out
);

    seg_t          seg;
    logic          pcw_mode;     // Bit 7 of the segment register
    map_result_t   chosen;

    map_result_t   fifo_mem [2];   // Queued results
    logic          wr_ptr;
    logic          rd_ptr;
    logic [1:0]    count;          // 0, 1 or 2 entries
    logic          push;
    logic          pop;
    logic          full;

    assign seg      = req.addr[15:14];
    assign pcw_mode = banks[seg][7];
    assign chosen   = pcw_mode ? pcw_result : cpc_result;

    assign full = (count == 2'd2);

    // Full queue still takes a request when the head leaves this cycle
    assign req_ready = !full || out_ready;
    assign out_valid = (count != 2'd0);
    assign out       = fifo_mem[rd_ptr];

    assign push = req_valid && req_ready;
    assign pop  = out_valid && out_ready;

    // Slot freed by a same-cycle pop is safe to reuse
    always_ff @(posedge clk_sys) begin
        if (push) begin
            fifo_mem[wr_ptr] <= chosen;
        end
    end

    always_ff @(posedge clk_sys) begin
        if (reset) begin
            wr_ptr <= 1'b0;
            rd_ptr <= 1'b0;
            count  <= 2'd0;
        end else begin
            if (push) begin
                wr_ptr <= ~wr_ptr;
            end
            if (pop) begin
                rd_ptr <= ~rd_ptr;
            end

            // Occupancy follows push/pop pair
            case ({push, pop})
                2'b10: begin
                    count <= count + 2'd1;
                end
                2'b01: begin
                    count <= count - 2'd1;
                end
                default: begin
                    count <= count;       // Idle or push and pop together
                end
            endcase
        end
    end

endmodule

// File: design/pcw_memory_mapper.sv
// ------------------------------
// PCW memory mapper
// Top level of the paging unit, Z80
// address in, 21-bit RAM address out
// ------------------------------

`timescale 1ns/1ps

module pcw_memory_mapper
    import pcw_mem_pkg::*;
(
    input  logic                  clk_sys,
    input  logic                  reset,
    input  mem_size_e             mem_size,      // Run-time RAM size
    input  logic                  io_wr_valid,
    input  io_wr_t                io_wr,
    input  logic                  req_valid,
    output logic                  req_ready,
    input  mem_req_t              req,
    output logic                  out_valid,
    input  logic                  out_ready,
    output map_result_t           out
);

    bank_reg_t [3:0]   banks;         // F0-F3
    bank_reg_t         lock;          // F4
    map_result_t       pcw_result;
    map_result_t       cpc_result;

    // Paging registers written by CPU OUT cycles
    bank_registers bank_registers_i (
        .clk_sys     (clk_sys),
        .reset       (reset),
        .io_wr_valid (io_wr_valid),
        .io_wr       (io_wr),
        .banks       (banks),
        .lock        (lock)
    );

    // Both maps run side by side on the unregistered request
    pcw_bank_map pcw_bank_map_i (
        .req         (req),
        .banks       (banks),
        .mem_size    (mem_size),
        .pcw_result  (pcw_result)
    );

    cpc_bank_map cpc_bank_map_i (
        .req         (req),
        .banks       (banks),
        .lock        (lock),
        .cpc_result  (cpc_result)
    );

    // Mode select and output queue
    phys_addr_stage phys_addr_stage_i (
        .clk_sys     (clk_sys),
        .reset       (reset),
        .req_valid   (req_valid),
        .req_ready   (req_ready),
        .req         (req),
        .banks       (banks),
        .pcw_result  (pcw_result),
        .cpc_result  (cpc_result),
        .out_valid   (out_valid),
        .out_ready   (out_ready),
        .out         (out)
    );

endmodule

// File: tb/mapper_vectors.svh
// ------------------------------
// Mapper stimulus table
// Register writes, back-pressure
// switches and requests with their
// expected physical addresses
// ------------------------------

`ifndef MAPPER_VECTORS_SVH
`define MAPPER_VECTORS_SVH

// Rows are write_port(port, data), set_backpressure(on) or
// expect_map(name, mem size, cpu addr, write, expected phys addr)
task automatic build_vectors();
    // Reset values 80-83 give an identity map in PCW mode
    expect_map("reset_seg0_rd", mem_2m, 16'h0123, 1'b0, 21'h000123);
    expect_map("reset_seg1_wr", mem_2m, 16'h4567, 1'b1, 21'h004567);
    expect_map("reset_seg2_rd", mem_2m, 16'h89ab, 1'b0, 21'h0089ab);
    expect_map("reset_seg3_wr", mem_2m, 16'hcdef, 1'b1, 21'h00cdef);

    // Bank 7f with top bits cut by RAM size
    write_port(8'hf1, 8'hff);
    expect_map("mask_256k", mem_256k, 16'h7abc, 1'b0, 21'h03fabc);
    expect_map("mask_512k", mem_512k, 16'h7abc, 1'b0, 21'h07fabc);
    expect_map("mask_1m",   mem_1m,   16'h7abc, 1'b1, 21'h0ffabc);
    expect_map("mask_2m",   mem_2m,   16'h7abc, 1'b0, 21'h1ffabc);

    // Bank 15 loses only bit 4 on 256K
    write_port(8'hf1, 8'h95);
    expect_map("bank15_256k", mem_256k, 16'h4000, 1'b0, 21'h014000);
    expect_map("bank15_2m",   mem_2m,   16'h7fff, 1'b0, 21'h057fff);

    // Seg 2 in CPC mode with read bank 5 and write bank 3 unlocked
    write_port(8'hf2, 8'h53);
    write_port(8'hf4, 8'h01);
    expect_map("cpc_wr_low",    mem_2m, 16'h8123, 1'b1, 21'h00c123);
    expect_map("cpc_rd_high",   mem_2m, 16'h8123, 1'b0, 21'h014123);
    write_port(8'hf4, 8'h40);                       // Lock seg 2 only
    expect_map("cpc_rd_locked", mem_2m, 16'h8123, 1'b0, 21'h00c123);

    // Seg 3 CPC with read 7 and write 6 while its lock bit stays clear
    write_port(8'hf3, 8'h7e);
    expect_map("cpc_rd_bank7", mem_256k, 16'hc010, 1'b0, 21'h01c010);
    expect_map("cpc_wr_bank6", mem_2m,   16'hffff, 1'b1, 21'h01bfff);

    // Stray ports must not disturb any segment
    write_port(8'hf5, 8'h00);
    write_port(8'h70, 8'h12);
    write_port(8'he4, 8'hff);
    expect_map("mix_seg0_pcw", mem_2m, 16'h0040, 1'b0, 21'h000040);
    expect_map("mix_seg1_pcw", mem_2m, 16'h4001, 1'b0, 21'h054001);
    expect_map("mix_seg2_cpc", mem_2m, 16'h8000, 1'b0, 21'h00c000);
    expect_map("mix_seg3_cpc", mem_2m, 16'hc000, 1'b0, 21'h01c000);

    // Back-to-back burst under random out_ready
    set_backpressure(1'b1);
    expect_map("burst_0", mem_2m,   16'h0001, 1'b0, 21'h000001);
    expect_map("burst_1", mem_2m,   16'h4002, 1'b0, 21'h054002);
    expect_map("burst_2", mem_256k, 16'h4003, 1'b0, 21'h014003);
    expect_map("burst_3", mem_2m,   16'h8004, 1'b1, 21'h00c004);
    expect_map("burst_4", mem_2m,   16'hc005, 1'b0, 21'h01c005);
    expect_map("burst_5", mem_2m,   16'hc006, 1'b1, 21'h018006);
    expect_map("burst_6", mem_512k, 16'h0007, 1'b1, 21'h000007);
    expect_map("burst_7", mem_1m,   16'h7ff8, 1'b0, 21'h057ff8);
    expect_map("burst_8", mem_2m,   16'h8ffc, 1'b0, 21'h00cffc);
    expect_map("burst_9", mem_2m,   16'h3ffd, 1'b1, 21'h003ffd);
    set_backpressure(1'b0);
endtask

`endif

// File: tb/tb_pcw_memory_mapper.sv
// ------------------------------
// PCW memory mapper testbench
// Table driven requests and port
// writes, scoreboard on the output
// ------------------------------

`timescale 1ns/1ps

module tb_pcw_memory_mapper
    import pcw_mem_pkg::*;
();

    localparam int REQ_TIMEOUT   = 200;   // Cycles per request
    localparam int DRAIN_TIMEOUT = 400;

    typedef enum logic [1:0] {row_io, row_req, row_pressure} row_kind_e;

    typedef struct {
        row_kind_e   kind;
        string       name;
        io_port_t    port;
        logic [7:0]  data;      // Port data or back-pressure enable in bit 0
        mem_size_e   size;
        cpu_addr_t   addr;
        logic        write;
        phys_addr_t  exp;
    } vec_row_t;

    logic         clk_sys = 1'b0;
    logic         reset;
    mem_size_e    mem_size;
    logic         io_wr_valid;
    io_wr_t       io_wr;
    logic         req_valid;
    logic         req_ready;
    mem_req_t     req;
    logic         out_valid;
    logic         out_ready = 1'b1;
    map_result_t  out;

    vec_row_t     rows [$];
    map_result_t  exp_q [$];       // In-flight results oldest first
    string        name_q [$];
    map_result_t  cur_exp;         // Expected result of the driven request
    string        cur_name;
    map_result_t  exp_head;
    string        name_head;
    logic         random_ready;
    logic         timed_out;
    int           check_errors;
    int           timeout_errors;
    int           outputs_seen;

    always #2 clk_sys = ~clk_sys;   // 4 ns period

    pcw_memory_mapper pcw_memory_mapper_i (
        .clk_sys     (clk_sys),
        .reset       (reset),
        .mem_size    (mem_size),
        .io_wr_valid (io_wr_valid),
        .io_wr       (io_wr),
        .req_valid   (req_valid),
        .req_ready   (req_ready),
        .req         (req),
        .out_valid   (out_valid),
        .out_ready   (out_ready),
        .out         (out)
    );

    task automatic write_port(input io_port_t port, input logic [7:0] data);
        vec_row_t row;
        row.kind = row_io;
        row.name = "io";
        row.port = port;
        row.data = data;
        rows.push_back(row);
    endtask

    task automatic expect_map(input string name, input mem_size_e size, input cpu_addr_t addr,
                              input logic write, input phys_addr_t exp);
        vec_row_t row;
        row.kind  = row_req;
        row.name  = name;
        row.size  = size;
        row.addr  = addr;
        row.write = write;
        row.exp   = exp;
        rows.push_back(row);
    endtask

    task automatic set_backpressure(input logic on);
        vec_row_t row;
        row.kind = row_pressure;
        row.name = "pressure";
        row.data = {7'd0, on};
        rows.push_back(row);
    endtask

    `include "mapper_vectors.svh"

    // Strobes drop at the falling edge that starts each row
    task automatic apply_row(input vec_row_t row);
        int waited;
        @(negedge clk_sys);
        req_valid   = 1'b0;
        io_wr_valid = 1'b0;
        case (row.kind)
            row_io: begin
                io_wr_valid = 1'b1;                      // Single cycle strobe
                io_wr       = '{port: row.port, data: row.data};
            end
            row_pressure: begin
                @(posedge clk_sys);                      // Ready driver reads it on negedge
                random_ready = row.data[0];
            end
            default: begin
                mem_size  = row.size;
                req       = '{addr: row.addr, write: row.write};
                cur_exp   = '{addr: row.exp, write: row.write};
                cur_name  = row.name;
                req_valid = 1'b1;
                waited    = 0;
                @(posedge clk_sys);
                while (!req_ready && waited < REQ_TIMEOUT) begin
                    waited++;
                    @(posedge clk_sys);
                end
                if (!req_ready) begin
                    timeout_errors++;
                    timed_out = 1'b1;
                    $display("Request %s was never accepted", row.name);
                end
            end
        endcase
    endtask

    // Random stall of the output side
    always @(negedge clk_sys) begin
        out_ready = random_ready ? ($urandom_range(3, 0) != 0) : 1'b1;
    end

    // Queue size tracks DUT occupancy before this edge
    always @(posedge clk_sys) begin
        if (!reset) begin
            if (!req_ready && exp_q.size() != 2) begin
                check_errors++;
                $display("req_ready low with %0d results pending", exp_q.size());
            end
            if (out_valid != (exp_q.size() != 0)) begin
                check_errors++;
                $display("out_valid is %b with %0d results pending", out_valid, exp_q.size());
            end
            if (out_valid && out_ready && exp_q.size() != 0) begin
                exp_head  = exp_q.pop_front();
                name_head = name_q.pop_front();
                outputs_seen++;
                if (out !== exp_head) begin
                    check_errors++;
                    $display("CHECK FAILED %s expected %h/%b actual %h/%b", name_head,
                             exp_head.addr, exp_head.write, out.addr, out.write);
                end
            end
            if (req_valid && req_ready) begin
                exp_q.push_back(cur_exp);
                name_q.push_back(cur_name);
            end
        end
    end

    initial begin
        int waited;
        void'($urandom(32'hfcdb_aa7d));
        reset          = 1'b1;
        mem_size       = mem_2m;
        io_wr_valid    = 1'b0;
        io_wr          = '0;
        req_valid      = 1'b0;
        req            = '0;
        cur_exp        = '0;
        cur_name       = "";
        random_ready   = 1'b0;
        timed_out      = 1'b0;
        check_errors   = 0;
        timeout_errors = 0;
        outputs_seen   = 0;
        build_vectors();

        repeat (4) @(posedge clk_sys);
        @(negedge clk_sys);
        reset = 1'b0;

        foreach (rows[i]) begin
            if (!timed_out) begin
                apply_row(rows[i]);
            end
        end
        @(negedge clk_sys);
        req_valid   = 1'b0;
        io_wr_valid = 1'b0;

        // Let the queue empty
        waited = 0;
        while (exp_q.size() != 0 && waited < DRAIN_TIMEOUT) begin
            waited++;
            @(posedge clk_sys);
        end
        if (exp_q.size() != 0) begin
            timeout_errors++;
            $display("Timed out with %0d results still queued", exp_q.size());
        end

        $display("Summary: %0d check errors, %0d timeouts, %0d outputs checked",
                 check_errors, timeout_errors, outputs_seen);
        if (check_errors == 0 && timeout_errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

// File: src.f
+incdir+tb
design/pcw_mem_pkg.sv
design/bank_registers.sv
design/pcw_bank_map.sv
design/cpc_bank_map.sv
design/phys_addr_stage.sv
design/pcw_memory_mapper.sv
tb/tb_pcw_memory_mapper.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the PCW memory mapper testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

verilator --binary --timing -f src.f \
    --top-module tb_pcw_memory_mapper \
    -Mdir "$OBJ" -o sim_tb
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

"./$OBJ/sim_tb" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -qx '>>> PASS' "$LOG"; then
    exit 0
fi

echo "Pass message not found in $LOG"
exit 1
